// ==== design/uart_pkg.sv ====
package uart_pkg;

    // Clock cycles per divider tick
    localparam int CLK_DIV = 4;
    // Divider ticks per serial bit, so one bit is 16 clocks
    localparam int TICKS_PER_BIT = 4;
    // Wait from the start edge to the middle of the start bit
    localparam int HALF_BIT_TICKS = TICKS_PER_BIT / 2;
    // Two bit periods, used for the two stop bits and the error hold-off
    localparam int TWO_BIT_TICKS = 2 * TICKS_PER_BIT;
    localparam int DATA_BITS = 8;

    // Receive channels feeding the shared FIFO
    localparam int NUM_CH = 2;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [DATA_BITS-1:0] byte_t;
    typedef logic [$clog2(NUM_CH)-1:0] chan_t;
    // Countdown of divider ticks inside one bit or delay
    typedef logic [3:0] tick_cnt_t;
    // Data bits still to shift
    typedef logic [3:0] bit_cnt_t;
    typedef logic [10:0] div_cnt_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    // One bit wider than a pointer so a full FIFO is representable
    typedef logic [FIFO_PTR_W:0] fifo_cnt_t;

    // Byte tagged with the channel it arrived on
    typedef struct packed {
        chan_t chan;
        byte_t data;
    } fifo_word_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_CHECK_START,
        RX_READ_BITS,
        RX_CHECK_STOP,
        RX_ERROR,
        RX_RECEIVED,
        RX_DELAY_RESTART
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SENDING,
        TX_DELAY_RESTART
    } tx_state_t;

endpackage

// ==== design/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx,
    input  logic            grant,
    output logic            pending,
    output uart_pkg::byte_t data,
    output logic            rx_error,
    output logic            overrun
);
    import uart_pkg::*;

    rx_state_t state;
    div_cnt_t  div_cnt;
    tick_cnt_t countdown;
    bit_cnt_t  bits_left;
    byte_t     shift_reg;
    logic      tick;
    logic      expired;
    logic      stop_ok;

    // One divider tick every CLK_DIV clocks
    assign tick = (div_cnt == '0);
    // Countdown ends on the tick that would take it to zero
    assign expired = tick && (countdown == tick_cnt_t'(1));
    // Good stop bit seen at mid-bit, the byte is complete
    assign stop_ok = (state == RX_CHECK_STOP) && expired && rx;
    // Error state lasts exactly one cycle
    assign rx_error = (state == RX_ERROR);

    // Divider restarts on the falling start edge so sampling lands mid-bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= div_cnt_t'(CLK_DIV - 1);
        end else if (((state == RX_IDLE) && !rx) || tick) begin
            div_cnt <= div_cnt_t'(CLK_DIV - 1);
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            countdown <= '0;
            bits_left <= '0;
        end else begin
            // Free countdown, the state cases below override it when reloading
            if (tick && (countdown != '0)) begin
                countdown <= countdown - 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    // Low line means a possible start bit
                    if (!rx) begin
                        countdown <= tick_cnt_t'(HALF_BIT_TICKS);
                        state     <= RX_CHECK_START;
                    end
                end
                RX_CHECK_START: begin
                    if (expired) begin
                        // Still low at mid start bit, frame accepted
                        if (!rx) begin
                            countdown <= tick_cnt_t'(TICKS_PER_BIT);
                            bits_left <= bit_cnt_t'(DATA_BITS);
                            state     <= RX_READ_BITS;
                        end else begin
                            state <= RX_ERROR;
                        end
                    end
                end
                RX_READ_BITS: begin
                    if (expired) begin
                        countdown <= tick_cnt_t'(TICKS_PER_BIT);
                        bits_left <= bits_left - 1'b1;
                        // Last data bit taken, next sample is the stop bit
                        if (bits_left == bit_cnt_t'(1)) begin
                            state <= RX_CHECK_STOP;
                        end
                    end
                end
                RX_CHECK_STOP: begin
                    if (expired) begin
                        state <= rx ? RX_RECEIVED : RX_ERROR;
                    end
                end
                RX_ERROR: begin
                    // Ignore the line for two bit periods
                    countdown <= tick_cnt_t'(TWO_BIT_TICKS);
                    state     <= RX_DELAY_RESTART;
                end
                RX_DELAY_RESTART: begin
                    if (expired) begin
                        state <= RX_IDLE;
                    end
                end
                RX_RECEIVED: begin
                    state <= RX_IDLE;
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // LSB arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if ((state == RX_READ_BITS) && expired) begin
            shift_reg <= {rx, shift_reg[DATA_BITS-1:1]};
        end
    end

    // Pending flag with overrun detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            overrun <= 1'b0;
        end else begin
            overrun <= 1'b0;
            if (stop_ok && pending && !grant) begin
                // Held byte still waiting, the new one is lost
                overrun <= 1'b1;
            end else if (stop_ok) begin
                pending <= 1'b1;
            end else if (grant) begin
                pending <= 1'b0;
            end
        end
    end

    // Hold register, free when empty or being granted this cycle
    always_ff @(posedge clk) begin
        if (stop_ok && (!pending || grant)) begin
            data <= shift_reg;
        end
    end

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fifo_empty,
    input  uart_pkg::fifo_word_t head,
    output logic                 pop,
    output logic                 tx,
    output logic                 tx_busy,
    output uart_pkg::chan_t      tx_chan
);
    import uart_pkg::*;

    tx_state_t state;
    div_cnt_t  div_cnt;
    tick_cnt_t countdown;
    bit_cnt_t  bits_left;
    byte_t     shift_reg;
    logic      tick;
    logic      expired;

    // Take the head word whenever idle and something is queued
    assign pop = (state == TX_IDLE) && !fifo_empty;
    assign tx_busy = (state != TX_IDLE);
    assign tick = (div_cnt == '0);
    assign expired = tick && (countdown == tick_cnt_t'(1));

    // Divider aligned to the start bit edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= div_cnt_t'(CLK_DIV - 1);
        end else if (pop || tick) begin
            div_cnt <= div_cnt_t'(CLK_DIV - 1);
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= TX_IDLE;
            tx        <= 1'b1;
            countdown <= '0;
            bits_left <= '0;
            tx_chan   <= '0;
        end else begin
            if (tick && (countdown != '0)) begin
                countdown <= countdown - 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    // Start bit goes out on the same edge as the pop
                    if (pop) begin
                        tx        <= 1'b0;
                        countdown <= tick_cnt_t'(TICKS_PER_BIT);
                        bits_left <= bit_cnt_t'(DATA_BITS);
                        tx_chan   <= head.chan;
                        state     <= TX_SENDING;
                    end
                end
                TX_SENDING: begin
                    if (expired) begin
                        if (bits_left != '0) begin
                            tx        <= shift_reg[0];
                            bits_left <= bits_left - 1'b1;
                            countdown <= tick_cnt_t'(TICKS_PER_BIT);
                        end else begin
                            // Both stop bits as one long high period
                            tx        <= 1'b1;
                            countdown <= tick_cnt_t'(TWO_BIT_TICKS);
                            state     <= TX_DELAY_RESTART;
                        end
                    end
                end
                TX_DELAY_RESTART: begin
                    if (expired) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // Data shifts out LSB first
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_reg <= head.data;
        end else if ((state == TX_SENDING) && expired && (bits_left != '0)) begin
            shift_reg <= {1'b0, shift_reg[DATA_BITS-1:1]};
        end
    end

endmodule

// ==== design/rx_arbiter.sv ====
`timescale 1ns/10ps

module rx_arbiter (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [uart_pkg::NUM_CH-1:0]           pending,
    input  uart_pkg::byte_t [uart_pkg::NUM_CH-1:0] data,
    input  logic                                  fifo_full,
    output logic [uart_pkg::NUM_CH-1:0]           grant,
    output logic                                  wr_en,
    output uart_pkg::fifo_word_t                  wr_word
);
    import uart_pkg::*;

    chan_t last_grant;

    // Search starts one past the last winner, first pending one takes the port
    always_comb begin
        chan_t idx;
        logic  found;
        grant   = '0;
        wr_en   = 1'b0;
        wr_word = '0;
        found   = 1'b0;
        idx     = '0;
        for (int i = 1; i <= NUM_CH; i++) begin
            idx = chan_t'((int'(last_grant) + i) % NUM_CH);
            // Full FIFO stalls everyone, bytes stay in the engines
            if (!found && pending[idx] && !fifo_full) begin
                found        = 1'b1;
                grant[idx]   = 1'b1;
                wr_en        = 1'b1;
                wr_word.chan = idx;
                wr_word.data = data[idx];
            end
        end
    end

    // Starting at the last channel makes channel 0 win the first tie
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_grant <= chan_t'(NUM_CH - 1);
        end else if (wr_en) begin
            last_grant <= wr_word.chan;
        end
    end

endmodule

// ==== design/byte_fifo.sv ====
`timescale 1ns/10ps

module byte_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  uart_pkg::fifo_word_t wr_word,
    input  logic                 rd_en,
    output uart_pkg::fifo_word_t head,
    output logic                 full,
    output logic                 empty
);
    import uart_pkg::*;

    fifo_word_t mem [FIFO_DEPTH];
    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  rd_ptr;
    fifo_cnt_t  count;
    logic       push;
    logic       pull;

    assign full = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign empty = (count == '0);
    // Writes to a full or reads from an empty buffer are ignored
    assign push = wr_en && !full;
    assign pull = rd_en && !empty;
    // Head is read straight from storage
    assign head = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= (rd_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count unchanged
            case ({push, pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_word;
        end
    end

endmodule

// ==== design/uart_concentrator.sv ====
`timescale 1ns/10ps

module uart_concentrator (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [uart_pkg::NUM_CH-1:0] rx,
    output logic                        tx,
    output logic                        tx_busy,
    output uart_pkg::chan_t             tx_chan,
    output logic [uart_pkg::NUM_CH-1:0] rx_error,
    output logic [uart_pkg::NUM_CH-1:0] overrun
);
    import uart_pkg::*;

    logic [NUM_CH-1:0]  pending;
    logic [NUM_CH-1:0]  grant;
    byte_t [NUM_CH-1:0] rx_data;
    logic               fifo_wr_en;
    logic               fifo_full;
    logic               fifo_empty;
    logic               fifo_pop;
    fifo_word_t         fifo_wr_word;
    fifo_word_t         fifo_head;

    // One receive engine per input line
    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_rx
        uart_rx u_rx (
            .clk      (clk),
            .rst_n    (rst_n),
            .rx       (rx[ch]),
            .grant    (grant[ch]),
            .pending  (pending[ch]),
            .data     (rx_data[ch]),
            .rx_error (rx_error[ch]),
            .overrun  (overrun[ch])
        );
    end

    rx_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .pending   (pending),
        .data      (rx_data),
        .fifo_full (fifo_full),
        .grant     (grant),
        .wr_en     (fifo_wr_en),
        .wr_word   (fifo_wr_word)
    );

    byte_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (fifo_wr_en),
        .wr_word (fifo_wr_word),
        .rd_en   (fifo_pop),
        .head    (fifo_head),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    // Single outgoing line, tagged with the source channel
    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_empty (fifo_empty),
        .head       (fifo_head),
        .pop        (fifo_pop),
        .tx         (tx),
        .tx_busy    (tx_busy),
        .tx_chan    (tx_chan)
    );

endmodule

// ==== verif/tb_uart_concentrator.sv ====
`timescale 1ns/10ps

module tb_uart_concentrator;
    import uart_pkg::*;

    // One serial bit in clocks
    localparam int BIT_CLKS = CLK_DIV * TICKS_PER_BIT;
    // Clocks the monitor waits for a start bit
    localparam int WAIT_LIMIT = 400;
    localparam int BURST_LEN = 12;
    localparam int NUM_ROWS = 10;

    // Which lines send what, and which channel tx should show first
    typedef struct packed {
        logic [NUM_CH-1:0] mask;
        byte_t             data0;
        byte_t             data1;
        logic [7:0]        offset1;
        logic              stop_good;
        logic              short_start;
        chan_t             first_chan;
    } stim_row_t;

    logic              clk;
    logic              rst_n;
    logic [NUM_CH-1:0] rx_line;
    logic              tx;
    logic              tx_busy;
    chan_t             tx_chan;
    logic [NUM_CH-1:0] rx_error;
    logic [NUM_CH-1:0] overrun;

    stim_row_t   stim [NUM_ROWS];
    byte_t       sent [NUM_CH][BURST_LEN];
    byte_t       rcv_data_q [$];
    chan_t       rcv_chan_q [$];
    int          err_pulses [NUM_CH];
    int          ovr_pulses [NUM_CH];
    int          mismatch_count;
    int          fail_count;
    logic [31:0] lfsr_state;

    uart_concentrator dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx_line),
        .tx       (tx),
        .tx_busy  (tx_busy),
        .tx_chan  (tx_chan),
        .rx_error (rx_error),
        .overrun  (overrun)
    );

    always #10 clk = ~clk;

    // Pulse counters, sampled on the quiet edge
    always @(negedge clk) begin
        for (int c = 0; c < NUM_CH; c++) begin
            if (rx_error[c] === 1'b1)
                err_pulses[c]++;
            if (overrun[c] === 1'b1)
                ovr_pulses[c]++;
        end
    end

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_chan(input string name, input chan_t got, input chan_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output byte_t b);
        for (int i = 0; i < DATA_BITS; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i] = lfsr_state[0];
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic drive_bit(input int ch, input logic value);
        rx_line[ch] = value;
        wait_clocks(BIT_CLKS);
    endtask

    // Start, 8 data bits LSB first, one stop bit
    task automatic send_frame(input int ch, input byte_t data, input logic stop_good,
                              input logic short_start);
        if (short_start) begin
            // Quarter bit low, gone before the mid-start sample
            rx_line[ch] = 1'b0;
            wait_clocks(BIT_CLKS / 4);
            rx_line[ch] = 1'b1;
            wait_clocks(BIT_CLKS);
        end else begin
            drive_bit(ch, 1'b0);
            for (int i = 0; i < DATA_BITS; i++) begin
                drive_bit(ch, data[i]);
            end
            drive_bit(ch, stop_good);
            rx_line[ch] = 1'b1;
        end
    endtask

    // Waits for a tx start edge, then samples every bit at mid-period
    task automatic recv_frame(output logic found);
        logic  prev;
        byte_t data;
        chan_t chan;
        int    i;
        found = 1'b0;
        prev = tx;
        i = 0;
        while (!found && i < WAIT_LIMIT) begin
            @(negedge clk);
            found = prev && !tx;
            prev = tx;
            i++;
        end
        if (found) begin
            // Half a clock past the edge already, seven more is mid start bit
            wait_clocks(BIT_CLKS / 2 - 1);
            check_flag("tx start bit", tx, 1'b0);
            check_flag("tx_busy", tx_busy, 1'b1);
            chan = tx_chan;
            for (int b = 0; b < DATA_BITS; b++) begin
                wait_clocks(BIT_CLKS);
                data[b] = tx;
            end
            // Two stop bits
            for (int s = 0; s < 2; s++) begin
                wait_clocks(BIT_CLKS);
                check_flag("tx stop bit", tx, 1'b1);
            end
            rcv_data_q.push_back(data);
            rcv_chan_q.push_back(chan);
        end
    endtask

    task automatic run_row(input int r);
        stim_row_t row;
        byte_t     exp_data [NUM_CH];
        chan_t     order [2];
        int        exp_n;
        int        err_before [NUM_CH];
        int        ovr_before [NUM_CH];
        logic      bad_frame;
        logic      found;
        row = stim[r];
        exp_data[0] = row.data0;
        exp_data[1] = row.data1;
        bad_frame = !row.stop_good || row.short_start;
        // Bad frames never reach tx
        exp_n = bad_frame ? 0 : $countones(row.mask);
        order[0] = row.first_chan;
        order[1] = ~row.first_chan;
        err_before = err_pulses;
        ovr_before = ovr_pulses;
        rcv_data_q.delete();
        rcv_chan_q.delete();
        fork
            begin
                if (row.mask[0])
                    send_frame(0, row.data0, row.stop_good, row.short_start);
            end
            begin
                if (row.mask[1]) begin
                    wait_clocks(int'(row.offset1));
                    send_frame(1, row.data1, row.stop_good, row.short_start);
                end
            end
            begin
                // One extra wait makes sure nothing else follows
                for (int k = 0; k <= exp_n; k++) begin
                    recv_frame(found);
                    if (found && k == exp_n) begin
                        $display("Row %0d: tx sent a frame that was not expected", r);
                        fail_count++;
                    end else if (!found && k < exp_n) begin
                        $display("Row %0d: timeout waiting for tx frame %0d", r, k);
                        fail_count++;
                    end
                end
            end
        join
        for (int k = 0; k < exp_n && k < rcv_data_q.size(); k++) begin
            check_chan("tx_chan", rcv_chan_q[k], order[k]);
            check_byte("tx data", rcv_data_q[k], exp_data[order[k]]);
        end
        for (int c = 0; c < NUM_CH; c++) begin
            check_flag($sformatf("rx_error[%0d] pulse", c), err_pulses[c] != err_before[c],
                       row.mask[c] && bad_frame);
            check_flag($sformatf("overrun[%0d] pulse", c), ovr_pulses[c] != ovr_before[c],
                       1'b0);
        end
    endtask

    // Back to back frames on both lines, more than tx can drain
    task automatic run_burst();
        int    fwd [NUM_CH];
        int    next_idx [NUM_CH];
        int    ovr_before [NUM_CH];
        int    pos;
        int    frames;
        chan_t ch;
        logic  found;
        ovr_before = ovr_pulses;
        fwd = '{default: 0};
        next_idx = '{default: 0};
        rcv_data_q.delete();
        rcv_chan_q.delete();
        for (int j = 0; j < BURST_LEN; j++) begin
            for (int c = 0; c < NUM_CH; c++) begin
                random_byte(sent[c][j]);
            end
        end
        fork
            begin
                for (int j = 0; j < BURST_LEN; j++)
                    send_frame(0, sent[0][j], 1'b1, 1'b0);
            end
            begin
                for (int j = 0; j < BURST_LEN; j++)
                    send_frame(1, sent[1][j], 1'b1, 1'b0);
            end
            begin
                // Drain until tx stays idle for a full wait, never more than was sent
                found = 1'b1;
                frames = 0;
                while (found && frames <= NUM_CH * BURST_LEN) begin
                    recv_frame(found);
                    frames++;
                end
                if (found) begin
                    $display("Burst: tx kept sending frames after %0d were received",
                             frames);
                    fail_count++;
                end
            end
        join
        // Forwarded bytes must be an in-order subset of what each line sent
        for (int k = 0; k < rcv_data_q.size(); k++) begin
            ch = rcv_chan_q[k];
            pos = next_idx[ch];
            while (pos < BURST_LEN && sent[ch][pos] !== rcv_data_q[k])
                pos++;
            if (pos == BURST_LEN) begin
                $display("Burst byte %h tagged channel %0d is out of order or mistagged",
                         rcv_data_q[k], ch);
                fail_count++;
            end else begin
                next_idx[ch] = pos + 1;
                fwd[ch]++;
            end
        end
        for (int c = 0; c < NUM_CH; c++) begin
            if (fwd[c] + ovr_pulses[c] - ovr_before[c] != BURST_LEN) begin
                $display("Burst channel %0d: %0d forwarded and %0d overruns for %0d sent",
                         c, fwd[c], ovr_pulses[c] - ovr_before[c], BURST_LEN);
                fail_count++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        rx_line = '1;
        lfsr_state = 32'h7dcc;
        mismatch_count = 0;
        fail_count = 0;
        err_pulses = '{default: 0};
        ovr_pulses = '{default: 0};
        // mask, data0, data1, ch1 offset, stop good, short start, first on tx
        // First tie straight after reset, channel 0 wins
        stim[0] = '{2'b11, 8'h81, 8'h7e, 8'd0, 1'b1, 1'b0, 1'b0};
        stim[1] = '{2'b01, 8'ha5, 8'h00, 8'd0, 1'b1, 1'b0, 1'b0};
        stim[2] = '{2'b10, 8'h00, 8'h3c, 8'd0, 1'b1, 1'b0, 1'b1};
        // Leaves channel 0 as the last winner
        stim[3] = '{2'b01, 8'h0f, 8'h00, 8'd0, 1'b1, 1'b0, 1'b0};
        stim[4] = '{2'b11, 8'hc3, 8'h18, 8'd0, 1'b1, 1'b0, 1'b1};
        stim[5] = '{2'b11, 8'h5a, 8'he7, 8'd40, 1'b1, 1'b0, 1'b0};
        // Low stop bit, then short start pulse
        stim[6] = '{2'b01, 8'h99, 8'h00, 8'd0, 1'b0, 1'b0, 1'b0};
        stim[7] = '{2'b10, 8'h00, 8'h66, 8'd0, 1'b0, 1'b0, 1'b1};
        stim[8] = '{2'b01, 8'h55, 8'h00, 8'd0, 1'b1, 1'b1, 1'b0};
        stim[9] = '{2'b10, 8'h00, 8'haa, 8'd0, 1'b1, 1'b1, 1'b1};
        wait_clocks(3);
        rst_n = 1'b1;
        wait_clocks(2);
        check_flag("tx after reset", tx, 1'b1);
        check_flag("tx_busy after reset", tx_busy, 1'b0);
        check_flag("rx_error after reset", |rx_error, 1'b0);
        check_flag("overrun after reset", |overrun, 1'b0);
        check_flag("grant after reset", |dut.grant, 1'b0);
        check_flag("fifo empty after reset", dut.fifo_empty, 1'b1);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        run_burst();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
design/uart_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/rx_arbiter.sv
design/byte_fifo.sv
design/uart_concentrator.sv
verif/tb_uart_concentrator.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the concentrator testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f filelist.f \
    --top-module tb_uart_concentrator \
    -o sim_concentrator || { echo "Build failed"; exit 1; }

# Verdict comes from the pass line in the simulator output
out=$(./obj_dir/sim_concentrator)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
